// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= fetch_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/fetch_pkg.sv
package fetch_pkg;

	// datapath widths
	localparam int xlen = 64;
	localparam int ins_w = 32;

	// first address fetched out of reset
	localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

	// instruction memory geometry, in 64-bit words
	localparam int imem_words = 256;
	localparam int imem_idx_w = 8;

	// kind codes, zero doubles as the idle value
	// nine codes, so three bits are not enough
	localparam int kind_w = 4;
	localparam logic [kind_w-1:0] kind_other   = 4'd0;
	localparam logic [kind_w-1:0] kind_alu     = 4'd1;
	localparam logic [kind_w-1:0] kind_alu_imm = 4'd2;
	localparam logic [kind_w-1:0] kind_load    = 4'd3;
	localparam logic [kind_w-1:0] kind_store   = 4'd4;
	localparam logic [kind_w-1:0] kind_branch  = 4'd5;
	localparam logic [kind_w-1:0] kind_jal     = 4'd6;
	localparam logic [kind_w-1:0] kind_jalr    = 4'd7;
	localparam logic [kind_w-1:0] kind_upper   = 4'd8;

	// rv64i major opcodes
	localparam logic [6:0] op_load   = 7'b000_0011;
	localparam logic [6:0] op_imm    = 7'b001_0011;
	localparam logic [6:0] op_auipc  = 7'b001_0111;
	localparam logic [6:0] op_imm32  = 7'b001_1011;
	localparam logic [6:0] op_store  = 7'b010_0011;
	localparam logic [6:0] op_reg    = 7'b011_0011;
	localparam logic [6:0] op_lui    = 7'b011_0111;
	localparam logic [6:0] op_reg32  = 7'b011_1011;
	localparam logic [6:0] op_branch = 7'b110_0011;
	localparam logic [6:0] op_jalr   = 7'b110_0111;
	localparam logic [6:0] op_jal    = 7'b110_1111;

	// one instruction word seen through each base format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} ins_word_u;

endpackage

// File: fetch/if_stage.sv
module if_stage import fetch_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  logic             kill,
	input  logic             r_valid,
	input  logic [xlen-1:0]  r_addr,
	input  logic [xlen-1:0]  r_data,
	output logic             ins_valid,
	output logic [xlen-1:0]  ins_pc,
	output logic [ins_w-1:0] ins
);

	// 32-bit half picked out of the memory word
	logic [ins_w-1:0] half;
	// incoming item survives this edge
	logic take;

	// bit 2 set means the upper half
	always_comb begin
		if (r_addr[2]) begin
			half = r_data[63:32];
		end else begin
			half = r_data[31:0];
		end
	end

	// anything still in memory stage is younger than the redirect
	assign take = r_valid & ~kill;

	always_ff @(posedge clk) begin
		if (reset) begin
			ins_valid <= 1'b0;
			ins       <= '0;
		end else if (!stall) begin
			if (take) begin
				ins_valid <= 1'b1;
				ins       <= half;
			end else begin
				// bubble, word cleared
				ins_valid <= 1'b0;
				ins       <= '0;
			end
		end
	end

	// pc follows the item, meaningful only with valid
	always_ff @(posedge clk) begin
		if (!stall) begin
			ins_pc <= r_addr;
		end
	end

endmodule

// File: fetch/imem_port.sv
module imem_port import fetch_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  load_en,
	input  logic [imem_idx_w-1:0] load_idx,
	input  logic [xlen-1:0]       load_data,
	input  logic                  fetch_req,
	input  logic [xlen-1:0]       fetch_pc,
	input  logic                  kill,
	output logic                  r_valid,
	output logic [xlen-1:0]       r_addr,
	output logic [xlen-1:0]       r_data
);

	// word array, no reset
	logic [xlen-1:0] mem [imem_words];

	// byte offset into the array
	logic [xlen-1:0] pc_off;
	// word index of the fetch address
	logic [imem_idx_w-1:0] rd_idx;

	assign pc_off = fetch_pc - reset_pc;

	// drop the byte-in-word bits, wrap on the array depth
	assign rd_idx = pc_off[imem_idx_w+2:3];

	// load port, one word per cycle
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_idx] <= load_data;
		end
	end

	// registered read, old data on a same-cycle write
	// address travels along for the half select
	always_ff @(posedge clk) begin
		if (fetch_req) begin
			r_data <= mem[rd_idx];
			r_addr <= fetch_pc;
		end
	end

	// no request means stall, so hold
	// a killed read lands as a bubble
	always_ff @(posedge clk) begin
		if (reset) begin
			r_valid <= 1'b0;
		end else if (fetch_req) begin
			r_valid <= ~kill;
		end
	end

endmodule

// File: fetch/pc_gen.sv
module pc_gen import fetch_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            stall,
	input  logic            redirect,
	input  logic [xlen-1:0] redirect_pc,
	output logic [xlen-1:0] fetch_pc,
	output logic            fetch_req,
	output logic            kill
);

	// current fetch address
	logic [xlen-1:0] pc;
	// pc advances this cycle
	logic step;

	// idle in reset and under stall
	assign step = ~reset & ~stall;

	// every unstalled cycle issues a read
	assign fetch_req = step;

	// a redirect only counts once the stall is gone
	// the source keeps redirect high until then
	assign kill = step & redirect;

	assign fetch_pc = pc;

	// priority: stall hold, redirect, then sequential
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (step) begin
			if (redirect) begin
				pc <= redirect_pc;
			end else begin
				// no compressed support, always 4 bytes
				pc <= pc + xlen'(4);
			end
		end
	end

endmodule

// File: fetch_top.f
common/fetch_pkg.sv
fetch/pc_gen.sv
fetch/imem_port.sv
fetch/if_stage.sv
src/ins_predecode.sv
src/fetch_top.sv
testbench/fetch_chk.sv
testbench/fetch_monitor.sv
testbench/fetch_tb.sv

// File: src/fetch_top.sv
module fetch_top import fetch_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	input  logic                  redirect,
	input  logic [xlen-1:0]       redirect_pc,
	input  logic                  load_en,
	input  logic [imem_idx_w-1:0] load_idx,
	input  logic [xlen-1:0]       load_data,
	output logic                  out_valid,
	output logic [xlen-1:0]       out_pc,
	output logic [ins_w-1:0]      out_ins,
	output logic [4:0]            out_rd,
	output logic [4:0]            out_rs1,
	output logic [4:0]            out_rs2,
	output logic [xlen-1:0]       out_imm,
	output logic [kind_w-1:0]     out_kind
);

	// pc generator to memory
	logic [xlen-1:0] fetch_pc;
	logic            fetch_req;
	logic            kill;

	// memory result to fetch stage
	logic            r_valid;
	logic [xlen-1:0] r_addr;
	logic [xlen-1:0] r_data;

	pc_gen pc_gen_i (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_pc    (fetch_pc),
		.fetch_req   (fetch_req),
		.kill        (kill)
	);

	imem_port imem_port_i (
		.clk       (clk),
		.reset     (reset),
		.load_en   (load_en),
		.load_idx  (load_idx),
		.load_data (load_data),
		.fetch_req (fetch_req),
		.fetch_pc  (fetch_pc),
		.kill      (kill),
		.r_valid   (r_valid),
		.r_addr    (r_addr),
		.r_data    (r_data)
	);

	// stage register feeds the outputs directly
	if_stage if_stage_i (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.kill      (kill),
		.r_valid   (r_valid),
		.r_addr    (r_addr),
		.r_data    (r_data),
		.ins_valid (out_valid),
		.ins_pc    (out_pc),
		.ins       (out_ins)
	);

	ins_predecode ins_predecode_i (
		.ins_valid (out_valid),
		.ins       (out_ins),
		.rd        (out_rd),
		.rs1       (out_rs1),
		.rs2       (out_rs2),
		.imm       (out_imm),
		.kind      (out_kind)
	);

endmodule

// File: src/ins_predecode.sv
module ins_predecode import fetch_pkg::*; (
	input  logic              ins_valid,
	input  logic [ins_w-1:0]  ins,
	output logic [4:0]        rd,
	output logic [4:0]        rs1,
	output logic [4:0]        rs2,
	output logic [xlen-1:0]   imm,
	output logic [kind_w-1:0] kind
);

	// instruction viewed in every format
	ins_word_u w;
	// class of the opcode before the valid gate
	logic [kind_w-1:0] op_kind;

	assign w = ins;

	// opcode sits in the same bits for all formats
	always_comb begin
		case (w.r_fmt.opcode)
			op_reg, op_reg32:  op_kind = kind_alu;
			op_imm, op_imm32:  op_kind = kind_alu_imm;
			op_load:           op_kind = kind_load;
			op_store:          op_kind = kind_store;
			op_branch:         op_kind = kind_branch;
			op_jal:            op_kind = kind_jal;
			op_jalr:           op_kind = kind_jalr;
			op_lui, op_auipc:  op_kind = kind_upper;
			default:           op_kind = kind_other;
		endcase
	end

	// fields per kind, all zero when idle or unknown
	always_comb begin
		rd   = '0;
		rs1  = '0;
		rs2  = '0;
		imm  = '0;
		kind = kind_other;
		if (ins_valid) begin
			kind = op_kind;
			case (op_kind)
				kind_alu: begin
					// register-register, no immediate
					rd  = w.r_fmt.rd;
					rs1 = w.r_fmt.rs1;
					rs2 = w.r_fmt.rs2;
				end
				kind_alu_imm, kind_load, kind_jalr: begin
					rd  = w.i_fmt.rd;
					rs1 = w.i_fmt.rs1;
					imm = {{52{w.i_fmt.imm[11]}}, w.i_fmt.imm};
				end
				kind_store: begin
					// no destination
					rs1 = w.s_fmt.rs1;
					rs2 = w.s_fmt.rs2;
					imm = {{52{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
				end
				kind_branch: begin
					rs1 = w.b_fmt.rs1;
					rs2 = w.b_fmt.rs2;
					// halfword offset, bit 0 always zero
					imm = {{51{w.b_fmt.imm_12}}, w.b_fmt.imm_12, w.b_fmt.imm_11,
						w.b_fmt.imm_10_5, w.b_fmt.imm_4_1, 1'b0};
				end
				kind_jal: begin
					rd  = w.j_fmt.rd;
					imm = {{43{w.j_fmt.imm_20}}, w.j_fmt.imm_20, w.j_fmt.imm_19_12,
						w.j_fmt.imm_11, w.j_fmt.imm_10_1, 1'b0};
				end
				kind_upper: begin
					// lui and auipc, already shifted into place
					rd  = w.u_fmt.rd;
					imm = {{32{w.u_fmt.imm[19]}}, w.u_fmt.imm, 12'b0};
				end
				default: begin
					// unknown opcode, fields stay zero
					kind = kind_other;
				end
			endcase
		end
	end

endmodule

// File: testbench/fetch_chk.sv
module fetch_chk import fetch_pkg::*; (
	input logic             clk,
	input logic             reset,
	input logic             stall,
	input logic             kill,
	input logic             out_valid,
	input logic [xlen-1:0]  out_pc,
	input logic [ins_w-1:0] out_ins
);

	// number of failed properties
	int fails = 0;

	// stage register comes out of reset empty
	valid_low_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else begin
			fails = fails + 1;
			$error("out_valid high in the cycle after reset");
		end

	// no compressed instructions, so word aligned
	pc_aligned: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> out_pc[1:0] == 2'b00)
		else begin
			fails = fails + 1;
			$error("out_pc not 4-byte aligned: %h", out_pc);
		end

	// two bubbles follow a taken redirect
	bubble_one_after_kill: assert property (@(posedge clk) disable iff (reset)
		kill |=> !out_valid)
		else begin
			fails = fails + 1;
			$error("out_valid high one cycle after a redirect");
		end

	bubble_two_after_kill: assert property (@(posedge clk) disable iff (reset)
		$past(kill) |=> !out_valid)
		else begin
			fails = fails + 1;
			$error("out_valid high two cycles after a redirect");
		end

	// stall freezes the outputs, pc only matters with valid
	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable(out_valid) && $stable(out_ins) && (!out_valid || $stable(out_pc)))
		else begin
			fails = fails + 1;
			$error("outputs moved while stall was high");
		end

endmodule

// File: testbench/fetch_monitor.sv
module fetch_monitor import fetch_pkg::*; (
	input logic                  clk,
	input logic                  reset,
	input logic                  stall,
	input logic                  redirect,
	input logic [xlen-1:0]       redirect_pc,
	input logic                  load_en,
	input logic [imem_idx_w-1:0] load_idx,
	input logic [xlen-1:0]       load_data,
	input logic                  out_valid,
	input logic [xlen-1:0]       out_pc,
	input logic [ins_w-1:0]      out_ins,
	input logic [4:0]            out_rd,
	input logic [4:0]            out_rs1,
	input logic [4:0]            out_rs2,
	input logic [xlen-1:0]       out_imm,
	input logic [kind_w-1:0]     out_kind
);

	// memory image, copied off the load port
	logic [xlen-1:0] prog [imem_words];
	// pc the next valid item has to carry
	logic [xlen-1:0] exp_pc;
	int value_errors = 0;
	int checked = 0;

	task automatic compare_field(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		if (got !== exp) begin
			value_errors = value_errors + 1;
			$display("[FAIL] %s got %h expected %h (pc %h)", name, got, exp, exp_pc);
		end
	endtask

	task automatic check_item();
		ins_word_u u;
		logic [xlen-1:0] off;
		logic [xlen-1:0] word;
		logic [4:0] e_rd;
		logic [4:0] e_rs1;
		logic [4:0] e_rs2;
		logic [xlen-1:0] e_imm;
		logic [kind_w-1:0] e_kind;
		off = (exp_pc - reset_pc) >> 3;
		word = prog[off[imem_idx_w-1:0]];
		// bit 2 picks the half
		u = exp_pc[2] ? word[63:32] : word[31:0];
		e_rd = '0;
		e_rs1 = '0;
		e_rs2 = '0;
		e_imm = '0;
		e_kind = kind_other;
		case (u.r_fmt.opcode)
			// reg-reg, both widths
			7'h33, 7'h3b: begin
				e_kind = kind_alu;
				e_rd = u.r_fmt.rd;
				e_rs1 = u.r_fmt.rs1;
				e_rs2 = u.r_fmt.rs2;
			end
			// i-type group: op-imm, op-imm-32, load, jalr
			7'h13, 7'h1b, 7'h03, 7'h67: begin
				e_kind = (u.i_fmt.opcode == 7'h03) ? kind_load :
					(u.i_fmt.opcode == 7'h67) ? kind_jalr : kind_alu_imm;
				e_rd = u.i_fmt.rd;
				e_rs1 = u.i_fmt.rs1;
				e_imm = 64'($signed(u.i_fmt.imm));
			end
			7'h23: begin
				e_kind = kind_store;
				e_rs1 = u.s_fmt.rs1;
				e_rs2 = u.s_fmt.rs2;
				e_imm = 64'($signed({u.s_fmt.imm_hi, u.s_fmt.imm_lo}));
			end
			7'h63: begin
				e_kind = kind_branch;
				e_rs1 = u.b_fmt.rs1;
				e_rs2 = u.b_fmt.rs2;
				e_imm = 64'($signed({u.b_fmt.imm_12, u.b_fmt.imm_11, u.b_fmt.imm_10_5,
					u.b_fmt.imm_4_1, 1'b0}));
			end
			7'h6f: begin
				e_kind = kind_jal;
				e_rd = u.j_fmt.rd;
				e_imm = 64'($signed({u.j_fmt.imm_20, u.j_fmt.imm_19_12, u.j_fmt.imm_11,
					u.j_fmt.imm_10_1, 1'b0}));
			end
			// lui, auipc
			7'h37, 7'h17: begin
				e_kind = kind_upper;
				e_rd = u.u_fmt.rd;
				e_imm = 64'($signed({u.u_fmt.imm, 12'h000}));
			end
			default: ;
		endcase
		compare_field("out_pc", out_pc, exp_pc);
		compare_field("out_ins", 64'(out_ins), 64'(u));
		compare_field("out_rd", 64'(out_rd), 64'(e_rd));
		compare_field("out_rs1", 64'(out_rs1), 64'(e_rs1));
		compare_field("out_rs2", 64'(out_rs2), 64'(e_rs2));
		compare_field("out_imm", out_imm, e_imm);
		compare_field("out_kind", 64'(out_kind), 64'(e_kind));
		checked = checked + 1;
	endtask

	always @(posedge clk) begin
		if (load_en) begin
			prog[load_idx] <= load_data;
		end
		if (reset) begin
			exp_pc <= reset_pc;
		end else begin
			// an item leaves the outputs on every edge without stall
			if (out_valid && !stall) begin
				check_item();
				exp_pc <= exp_pc + 64'd4;
			end
			// taken redirect wins over the sequential step
			if (redirect && !stall) begin
				exp_pc <= redirect_pc;
			end
		end
	end

endmodule

// File: testbench/fetch_tb.sv
module fetch_tb import fetch_pkg::*; ();

	localparam int prog_words = 64;
	localparam int rows = 7;

	logic                  clk;
	logic                  reset;
	logic                  stall;
	logic                  redirect;
	logic [xlen-1:0]       redirect_pc;
	logic                  load_en;
	logic [imem_idx_w-1:0] load_idx;
	logic [xlen-1:0]       load_data;
	logic                  out_valid;
	logic [xlen-1:0]       out_pc;
	logic [ins_w-1:0]      out_ins;
	logic [4:0]            out_rd;
	logic [4:0]            out_rs1;
	logic [4:0]            out_rs2;
	logic [xlen-1:0]       out_imm;
	logic [kind_w-1:0]     out_kind;

	logic [xlen-1:0] prog [prog_words];
	integer seed;
	int timeouts;

	// per row: cycles, stall bit per cycle mod 8, redirect, target offset from reset_pc
	int              row_cycles [rows] = '{30, 24, 12, 12, 16, 20, 10};
	logic [7:0]      row_stall  [rows] = '{8'h00, 8'h36, 8'h00, 8'h00, 8'h0f, 8'ha5, 8'h00};
	logic            row_redir  [rows] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
	logic [xlen-1:0] row_off    [rows] = '{64'h0, 64'h0, 64'h20, 64'h2c, 64'h34, 64'h40,
		64'h104};

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	fetch_top dut_i (.*);

	fetch_monitor mon_i (.*);

	// property checks inside the DUT, kill is internal
	bind fetch_top fetch_chk fetch_chk_i (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.kill      (kill),
		.out_valid (out_valid),
		.out_pc    (out_pc),
		.out_ins   (out_ins)
	);

	// random words, hand encodings of each kind in words 4 to 8
	task automatic build_program();
		for (int i = 0; i < prog_words; i++) begin
			prog[i] = {$random(seed), $random(seed)};
		end
		// add x3,x1,x2 then addi x5,x6,-1
		prog[4] = {32'hfff3_0293, 32'h0020_81b3};
		// ld x7,-8(x2) then sd x9,-16(x2)
		prog[5] = {32'hfe91_3823, 32'hff81_3383};
		// beq x1,x2,-4 then jal x1,-8
		prog[6] = {32'hff9f_f0ef, 32'hfe20_8ee3};
		// jalr x0,0(x1) then lui x10,0x80000
		prog[7] = {32'h8000_0537, 32'h0000_8067};
		// sub x1,x1,x2 then an unknown opcode
		prog[8] = {32'hffff_ffff, 32'h4020_80b3};
	endtask

	task automatic wait_valid(input string what);
		int n;
		n = 0;
		while (!out_valid && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (!out_valid) begin
			timeouts++;
			$display("timeout while waiting for the %s", what);
		end
	endtask

	task automatic run_table();
		for (int r = 0; r < rows; r++) begin
			for (int c = 0; c < row_cycles[r]; c++) begin
				@(negedge clk);
				// redirect is done once it saw a cycle without stall
				if (redirect && !stall) begin
					redirect = 1'b0;
				end
				stall = row_stall[r][c[2:0]];
				if (c == 0 && row_redir[r]) begin
					redirect = 1'b1;
					redirect_pc = reset_pc + row_off[r];
				end
			end
		end
	endtask

	initial begin
		seed = 31;
		timeouts = 0;
		reset = 1'b1;
		stall = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		load_en = 1'b0;
		load_idx = '0;
		load_data = '0;
		build_program();
		// load starts under reset, stall keeps fetch idle until the last word
		for (int i = 0; i < prog_words; i++) begin
			@(negedge clk);
			if (i == 9) begin
				reset = 1'b0;
			end
			load_en = 1'b1;
			load_idx = imem_idx_w'(i);
			load_data = prog[i];
		end
		@(negedge clk);
		load_en = 1'b0;
		stall = 1'b0;
		wait_valid("first instruction after reset");
		run_table();
		@(negedge clk);
		redirect = 1'b0;
		stall = 1'b0;
		wait_valid("pipeline to drain");
		@(negedge clk);
		if (mon_i.checked == 0) begin
			$display("no instruction ever reached the outputs");
		end
		$display("errors: value %0d, assertion %0d, timeout %0d (%0d instructions checked)",
			mon_i.value_errors, dut_i.fetch_chk_i.fails, timeouts, mon_i.checked);
		if (mon_i.value_errors == 0 && dut_i.fetch_chk_i.fails == 0 && timeouts == 0
			&& mon_i.checked > 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
